// File: src/pipelinePkg.sv
package pipelinePkg;

    // Truth table of a function of seven variables
    localparam int funcWidth = 128;

    // Orderings of variables 4, 5 and 6
    localparam int permCount = 6;

    localparam int summedWidth = 12; // Large enough for 6 x 128
    localparam int pcoeffWidth = 3;  // Counts 0 to 6

    // One FIFO word carries both results
    localparam int resultWidth = summedWidth + pcoeffWidth;

    // Edges from the accepting edge to the FIFO write edge
    localparam int pipeLatency = 4;

    // Number of set bits in one byte
    function automatic logic [3:0] countByte(input logic [7:0] value);
        logic [3:0] ones;
        ones = '0;
        for (int i = 0; i < 8; i++) begin
            ones = ones + 4'(value[i]);
        end
        return ones;
    endfunction

endpackage

// File: src/botStreamIf.sv
`timescale 1ns/100ps

interface botStreamIf import pipelinePkg::*; ();

    logic valid;                                        // Bot register holds a new candidate
    logic [funcWidth-1:0] bot;
    logic [permCount-1:0] validPermutations;            // Bit 0 is the identity
    logic [permCount-1:0][funcWidth-1:0] permutedBots;

    modport manager (
        output valid,
        output bot
    );

    // Named check because checker is a reserved word
    modport check (
        input  bot,
        output permutedBots,
        output validPermutations
    );

    modport consumer (
        input valid,
        input bot,
        input validPermutations,
        input permutedBots
    );

endinterface

// File: src/hyperpipe.sv
`timescale 1ns/100ps

module hyperpipe #(
    parameter int cycles = 2,
    parameter int width = 1
) (
    input  logic             clock,
    input  logic [width-1:0] dataIn,
    output logic [width-1:0] dataOut
);

    logic [width-1:0] stages [cycles];

    // Plain flops so the chain can be retimed and spread out
    always_ff @(posedge clock) begin
        stages[0] <= dataIn;
        for (int i = 1; i < cycles; i++) begin
            stages[i] <= stages[i-1];
        end
    end

    assign dataOut = stages[cycles-1]; // Oldest entry

    // A zero-length chain would leave dataOut undriven
    cyclesAtLeastOne: assert property (
        @(posedge clock) cycles >= 1
    ) else $error("hyperpipe needs at least one stage, cycles=%0d", cycles);

endmodule

// File: src/pipelineManager.sv
`timescale 1ns/100ps

module pipelineManager import pipelinePkg::*; #(
    parameter int fifoDepthLog2 = 5
) (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   ivalid,
    input  logic [funcWidth-1:0]   bot,
    input  logic [fifoDepthLog2:0] fifoUsed,
    input  logic                   resultWritten,
    output logic                   oready,
    botStreamIf.manager            stream
);

    localparam int fifoDepth = 2 ** fifoDepthLog2;
    localparam int flightWidth = $clog2(pipeLatency + 1);

    // Leave room for everything in flight plus the throttle register delay
    localparam logic [fifoDepthLog2:0] usedLimit = (fifoDepthLog2 + 1)'(fifoDepth - pipeLatency - 2);

    logic                   throttle;
    logic                   accept;
    logic [flightWidth-1:0] inFlight;

    assign oready = !throttle;
    assign accept = ivalid && oready; // Plain level pair, no handshake beyond this

    // Starts throttled so nothing is taken while the design leaves reset
    always_ff @(posedge clock) begin
        if (rst) begin
            throttle <= 1'b1;
        end else begin
            throttle <= fifoUsed >= usedLimit;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            stream.valid <= 1'b0;
        end else begin
            stream.valid <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            stream.bot <= bot;
        end
    end

    // Bots accepted whose result is not yet in the FIFO
    always_ff @(posedge clock) begin
        if (rst) begin
            inFlight <= '0;
        end else begin
            case ({accept, resultWritten})
                2'b10:   inFlight <= inFlight + 1'b1;
                2'b01:   inFlight <= inFlight - 1'b1;
                default: inFlight <= inFlight;
            endcase
        end
    end

    inFlightBound: assert property (
        @(posedge clock) disable iff (rst)
        inFlight <= flightWidth'(pipeLatency)
    ) else $error("in-flight count %0d above pipeline latency", inFlight);

    // A registered bot must come from a cycle where the throttle was open
    noAcceptWhileThrottled: assert property (
        @(posedge clock) disable iff (rst)
        stream.valid |-> !$past(throttle)
    ) else $error("bot accepted while throttled");

endmodule

// File: src/permuteCheck6.sv
`timescale 1ns/100ps

module permuteCheck6 import pipelinePkg::*; (
    input  logic [funcWidth-1:0] top,
    botStreamIf.check            stream
);

    localparam int idxWidth = $clog2(funcWidth);

    // Source variable for positions 4, 5 and 6, in the order
    // ABC, ACB, BAC, BCA, CAB, CBA
    localparam int varA [permCount] = '{4, 4, 5, 5, 6, 6};
    localparam int varB [permCount] = '{5, 6, 4, 6, 4, 5};
    localparam int varC [permCount] = '{6, 5, 6, 4, 5, 4};

    // Pure reindexing, no logic beyond wiring
    always_comb begin
        logic [idxWidth-1:0] srcIndex;
        srcIndex = '0;
        for (int p = 0; p < permCount; p++) begin
            for (int i = 0; i < funcWidth; i++) begin
                srcIndex = idxWidth'(i);       // Variables 0 to 3 stay put
                srcIndex[4] = i[varA[p]];
                srcIndex[5] = i[varB[p]];
                srcIndex[6] = i[varC[p]];
                stream.permutedBots[p][i] = stream.bot[srcIndex];
            end
        end
    end

    // Valid when the variant sits below top
    always_comb begin
        for (int p = 0; p < permCount; p++) begin
            stream.validPermutations[p] = ~|(stream.permutedBots[p] & ~top);
        end
    end

endmodule

// File: src/freeCountPipeline.sv
`timescale 1ns/100ps

module freeCountPipeline import pipelinePkg::*; (
    input  logic                   clock,
    input  logic                   rst,
    input  logic [funcWidth-1:0]   top,
    botStreamIf.consumer           stream,
    output logic                   resultValid,
    output logic [summedWidth-1:0] summedData,
    output logic [pcoeffWidth-1:0] pcoeffCount
);

    localparam int byteCount = funcWidth / 8;
    localparam int permFreeWidth = $clog2(funcWidth + 1);
    localparam int maskDelay = 2; // Stage 1 and stage 2

    logic [permCount-1:0][byteCount-1:0][3:0]     byteFree;
    logic [permCount-1:0][permFreeWidth-1:0]      permSum;
    logic [permCount-1:0][permFreeWidth-1:0]      permFree;
    logic [permCount-1:0]                         maskDelayed;
    logic [summedWidth-1:0]                       totalFree;
    logic [pcoeffWidth-1:0]                       validCount;
    logic                                         valid1;
    logic                                         valid2;

    // Valid mask rides alongside the counts up to stage 3
    hyperpipe #(
        .cycles (maskDelay),
        .width  (permCount)
    ) maskPipe (
        .clock   (clock),
        .dataIn  (stream.validPermutations),
        .dataOut (maskDelayed)
    );

    // Stage 1 counts the bits per byte set in top and clear in the variant
    always_ff @(posedge clock) begin
        for (int p = 0; p < permCount; p++) begin
            for (int b = 0; b < byteCount; b++) begin
                byteFree[p][b] <= countByte(top[b*8 +: 8] & ~stream.permutedBots[p][b*8 +: 8]);
            end
        end
    end

    // Stage 2 sums the bytes per permutation
    always_comb begin
        for (int p = 0; p < permCount; p++) begin
            permSum[p] = '0;
            for (int b = 0; b < byteCount; b++) begin
                permSum[p] = permSum[p] + permFreeWidth'(byteFree[p][b]);
            end
        end
    end

    always_ff @(posedge clock) begin
        permFree <= permSum;
    end

    // Stage 3 drops the counts of invalid permutations
    always_comb begin
        totalFree = '0;
        validCount = '0;
        for (int p = 0; p < permCount; p++) begin
            if (maskDelayed[p]) begin
                totalFree = totalFree + summedWidth'(permFree[p]);
                validCount = validCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        summedData <= totalFree;
        pcoeffCount <= validCount;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            valid1 <= stream.valid;
            valid2 <= valid1;
            resultValid <= valid2;
        end
    end

    validLatency: assert property (
        @(posedge clock) disable iff (rst)
        resultValid == $past(stream.valid, 3)
    ) else $error("resultValid out of step with stream valid");

endmodule

// File: src/fastFifo.sv
`timescale 1ns/100ps

module fastFifo #(
    parameter int width = 15,
    parameter int depthLog2 = 5
) (
    input  logic               clock,
    input  logic               rst,
    input  logic               writeEnable,
    input  logic [width-1:0]   dataIn,
    input  logic               readRequest,
    output logic [width-1:0]   dataOut,
    output logic               dataOutValid,
    output logic [depthLog2:0] usedw
);

    localparam int depth = 2 ** depthLog2;

    logic [width-1:0]     mem [depth];
    logic [depthLog2-1:0] writePtr;
    logic [depthLog2-1:0] readPtr;
    logic                 full;
    logic                 empty;
    logic                 doWrite;
    logic                 doRead;

    assign full = usedw == (depthLog2 + 1)'(depth);
    assign empty = usedw == '0;
    assign doWrite = writeEnable && !full; // Overflow is caught by the assertion below
    assign doRead = readRequest && !empty;

    always_ff @(posedge clock) begin
        if (doWrite) begin
            mem[writePtr] <= dataIn;
        end
    end

    // Pointers wrap naturally at the power of two depth
    always_ff @(posedge clock) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
        end else begin
            if (doWrite) begin
                writePtr <= writePtr + 1'b1;
            end
            if (doRead) begin
                readPtr <= readPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            usedw <= '0;
        end else begin
            case ({doWrite, doRead})
                2'b10:   usedw <= usedw + 1'b1;
                2'b01:   usedw <= usedw - 1'b1;
                default: usedw <= usedw;
            endcase
        end
    end

    // Registered read port, data and valid arrive one cycle after the read
    always_ff @(posedge clock) begin
        if (doRead) begin
            dataOut <= mem[readPtr];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            dataOutValid <= 1'b0;
        end else begin
            dataOutValid <= doRead;
        end
    end

    noWriteWhenFull: assert property (
        @(posedge clock) disable iff (rst)
        writeEnable |-> !full
    ) else $error("FIFO write while full, data lost");

    usedwInRange: assert property (
        @(posedge clock) disable iff (rst)
        usedw <= (depthLog2 + 1)'(depth)
    ) else $error("FIFO fill count %0d above depth", usedw);

endmodule

// File: src/openCLFullPipeline.sv
`timescale 1ns/100ps

module openCLFullPipeline import pipelinePkg::*; #(
    parameter int fifoDepthLog2 = 5,
    parameter int resetStages = 2
) (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   ivalid,
    input  logic                   iready,
    output logic                   ovalid,
    output logic                   oready,
    input  logic [funcWidth-1:0]   top,   // Constant for a whole run
    input  logic [funcWidth-1:0]   bot,
    output logic [summedWidth-1:0] summedDataOut,
    output logic [pcoeffWidth-1:0] pcoeffCountOut
);

    logic                   rstLocal;
    logic [fifoDepthLog2:0] fifoUsed;
    logic                   resultValid;
    logic [summedWidth-1:0] summedData;
    logic [pcoeffWidth-1:0] pcoeffCount;

    botStreamIf stream ();

    // Local reset tree
    hyperpipe #(
        .cycles (resetStages),
        .width  (1)
    ) rstPipe (
        .clock   (clock),
        .dataIn  (rst),
        .dataOut (rstLocal)
    );

    pipelineManager #(
        .fifoDepthLog2 (fifoDepthLog2)
    ) pipelineMngr (
        .clock         (clock),
        .rst           (rstLocal),
        .ivalid        (ivalid),
        .bot           (bot),
        .fifoUsed      (fifoUsed),
        .resultWritten (resultValid),
        .oready        (oready),
        .stream        (stream.manager)
    );

    permuteCheck6 permuteChecker (
        .top    (top),
        .stream (stream.check)
    );

    freeCountPipeline countPipe (
        .clock       (clock),
        .rst         (rstLocal),
        .top         (top),
        .stream      (stream.consumer),
        .resultValid (resultValid),
        .summedData  (summedData),
        .pcoeffCount (pcoeffCount)
    );

    // Results wait here until the host drains them
    fastFifo #(
        .width     (resultWidth),
        .depthLog2 (fifoDepthLog2)
    ) resultsBuffer (
        .clock        (clock),
        .rst          (rstLocal),
        .writeEnable  (resultValid),
        .dataIn       ({summedData, pcoeffCount}),
        .readRequest  (iready),
        .dataOut      ({summedDataOut, pcoeffCountOut}),
        .dataOutValid (ovalid),
        .usedw        (fifoUsed)
    );

endmodule

// File: testbench/tbOpenCLFullPipeline.sv
`timescale 1ns/100ps

module tbOpenCLFullPipeline import pipelinePkg::*; ();

    localparam int fifoDepth = 32;   // Default fifoDepthLog2 of the DUT
    localparam int waitLimit = 600;

    logic                   clock;
    logic                   rst;
    logic                   ivalid;
    logic                   iready;
    logic [funcWidth-1:0]   top;
    logic [funcWidth-1:0]   bot;
    logic                   ovalid;
    logic                   oready;
    logic [summedWidth-1:0] summedDataOut;
    logic [pcoeffWidth-1:0] pcoeffCountOut;

    logic [31:0]            lfsrState = 32'ha740_8081;
    logic [resultWidth-1:0] expectedQueue [$];
    logic [summedWidth-1:0] headSummed;
    logic [pcoeffWidth-1:0] headPcoeff;
    int                     acceptCount;
    int                     pulseCount;
    int                     readyMode;   // 0 drain, 1 stall, 2 random

    openCLFullPipeline i_dut (
        .clock          (clock),
        .rst            (rst),
        .ivalid         (ivalid),
        .iready         (iready),
        .ovalid         (ovalid),
        .oready         (oready),
        .top            (top),
        .bot            (bot),
        .summedDataOut  (summedDataOut),
        .pcoeffCountOut (pcoeffCountOut)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    // Galois LFSR, one step per bit
    function automatic logic nextBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h8020_0003;
        end
        return outBit;
    endfunction

    function automatic logic [funcWidth-1:0] randomWord(input int bits);
        logic [funcWidth-1:0] word;
        word = '0;
        for (int i = 0; i < bits; i++) begin
            word[i] = nextBit();
        end
        return word;
    endfunction

    // Upward closure of a few nonzero seeds, so bit 0 stays clear
    function automatic logic [funcWidth-1:0] monotoneTop();
        logic [funcWidth-1:0] truth;
        logic [6:0]           seed;
        truth = '0;
        for (int s = 0; s < 3; s++) begin
            seed = 7'(randomWord(7) & randomWord(7));
            if (seed == '0) begin
                seed = 7'h7f;
            end
            for (int i = 0; i < funcWidth; i++) begin
                if ((seed & ~7'(i)) == '0) begin
                    truth[i] = 1'b1;
                end
            end
        end
        return truth;
    endfunction

    // Variable 4 moves to position a, 5 to b, 6 to c
    function automatic logic [resultWidth-1:0] expectedResult(
        input logic [funcWidth-1:0] topValue,
        input logic [funcWidth-1:0] botValue
    );
        logic [funcWidth-1:0] variant;
        logic [6:0]           source;
        logic [6:0]           dest;
        int                   summed;
        int                   count;
        summed = 0;
        count = 0;
        for (int a = 4; a <= 6; a++) begin
            for (int b = 4; b <= 6; b++) begin
                for (int c = 4; c <= 6; c++) begin
                    if (a != b && a != c && b != c) begin
                        variant = '0;
                        for (int j = 0; j < funcWidth; j++) begin
                            source = 7'(j);
                            dest = source;
                            dest[a] = source[4];
                            dest[b] = source[5];
                            dest[c] = source[6];
                            variant[dest] = botValue[j];
                        end
                        if ((variant & ~topValue) == '0) begin
                            count++;
                            summed += $countones(topValue & ~variant);
                        end
                    end
                end
            end
        end
        return {summedWidth'(summed), pcoeffWidth'(count)};
    endfunction

    task automatic sendBot(input logic [funcWidth-1:0] value);
        int waited;
        waited = 0;
        @(posedge clock);
        ivalid <= 1'b1;
        bot <= value;
        @(posedge clock);
        while (!oready && waited < waitLimit) begin
            @(posedge clock);
            waited++;
        end
        if (!oready) begin
            abortRun("bot was never accepted, oready stayed low");
        end
        ivalid <= 1'b0;
    endtask

    task automatic waitDrained();
        int waited;
        waited = 0;
        while (expectedQueue.size() > 0 && waited < waitLimit) begin
            @(posedge clock);
            waited++;
        end
        if (expectedQueue.size() > 0) begin
            abortRun("results still outstanding after draining");
        end
    endtask

    always @(posedge clock) begin
        case (readyMode)
            0:       iready <= 1'b1;
            1:       iready <= 1'b0;
            default: iready <= nextBit();
        endcase
    end

    // Scoreboard, head of queue is the next expected result
    always @(posedge clock) begin
        if (rst) begin
            expectedQueue.delete();
        end else begin
            if (ivalid && oready) begin
                expectedQueue.push_back(expectedResult(top, bot));
                acceptCount++;
            end
            if (ovalid) begin
                if (expectedQueue.size() == 0) begin
                    abortRun("ovalid pulsed with no result outstanding");
                end else begin
                    void'(expectedQueue.pop_front());
                    pulseCount++;
                end
            end
            if (expectedQueue.size() > 0) begin
                {headSummed, headPcoeff} = expectedQueue[0];
            end
        end
    end

    summedCheck: assert property (
        @(posedge clock) disable iff (rst)
        ovalid |-> summedDataOut == headSummed
    ) else abortRun($sformatf("MISMATCH summedDataOut got 0x%h expected 0x%h",
        $sampled(summedDataOut), $sampled(headSummed)));

    pcoeffCheck: assert property (
        @(posedge clock) disable iff (rst)
        ovalid |-> pcoeffCountOut == headPcoeff
    ) else abortRun($sformatf("MISMATCH pcoeffCountOut got 0x%h expected 0x%h",
        $sampled(pcoeffCountOut), $sampled(headPcoeff)));

    // Stored plus in-flight results must always fit
    fifoMargin: assert property (
        @(posedge clock) disable iff (rst)
        int'(i_dut.fifoUsed) + int'(i_dut.pipelineMngr.inFlight) <= fifoDepth
    ) else abortRun("FIFO fill plus in-flight results exceeds the FIFO depth");

    closedMeansNoAccept: assert property (
        @(posedge clock) disable iff (rst)
        !oready |=> !i_dut.stream.valid
    ) else abortRun("a bot entered the pipeline while oready was low");

    initial begin
        int                   waited;
        int                   throttled;
        logic [funcWidth-1:0] value;
        clock = 1'b0;
        rst = 1'b1;
        ivalid = 1'b0;
        iready = 1'b0;
        bot = '0;
        readyMode = 0;
        acceptCount = 0;
        pulseCount = 0;
        headSummed = '0;
        headPcoeff = '0;
        top = monotoneTop();   // Fixed for the whole run
        repeat (5) @(posedge clock);
        rst <= 1'b0;

        // Quiet after reset, then oready opens
        @(posedge clock);
        resetQuiet: assert (ovalid === 1'b0 && expectedQueue.size() == 0)
            else abortRun("ovalid active or result present right after reset");
        waited = 0;
        while ((i_dut.rstLocal !== 1'b0 || oready !== 1'b1) && waited < waitLimit) begin
            @(posedge clock);
            waited++;
        end
        if (oready !== 1'b1) begin
            abortRun("oready never rose after reset");
        end

        for (int n = 0; n < 30; n++) begin
            value = randomWord(funcWidth) & randomWord(funcWidth);
            if (nextBit()) begin
                value = value & top; // Identity variant is valid
            end
            sendBot(value);
        end

        // Directed bots
        zeroBotKnown: assert (expectedResult(top, '0) ==
            {summedWidth'(6 * $countones(top)), pcoeffWidth'(6)})
            else abortRun("all-zero bot does not give six full free counts");
        sendBot('0);
        outsideBotKnown: assert (expectedResult(top, funcWidth'(1)) == '0)
            else abortRun("bot outside top does not give zero results");
        sendBot(funcWidth'(1));
        waitDrained();

        // Stall the host until the throttle has held for a while
        readyMode = 1;
        repeat (2) @(posedge clock);
        throttled = 0;
        waited = 0;
        while (throttled < 20 && waited < waitLimit) begin
            @(posedge clock);
            if (!oready) begin
                throttled++;
            end
            ivalid <= 1'b1;
            bot <= randomWord(funcWidth) & top;
            waited++;
        end
        if (throttled < 20) begin
            abortRun("oready did not fall while the FIFO backed up");
        end
        ivalid <= 1'b0;
        @(negedge clock);
        stallFill: assert (expectedQueue.size() <= fifoDepth)
            else abortRun("more results outstanding than the FIFO holds");
        readyMode = 0;
        waitDrained();

        readyMode = 2;
        for (int n = 0; n < 40; n++) begin
            sendBot(randomWord(funcWidth) & top);
            if (nextBit()) begin
                @(posedge clock);
            end
        end
        readyMode = 0;
        waitDrained();
        repeat (8) @(posedge clock);

        if (pulseCount == acceptCount && expectedQueue.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abortRun($sformatf("%0d results seen for %0d accepted bots",
                pulseCount, acceptCount));
        end
    end

endmodule

// File: src.f
src/pipelinePkg.sv
src/botStreamIf.sv
src/hyperpipe.sv
src/pipelineManager.sv
src/permuteCheck6.sv
src/freeCountPipeline.sv
src/fastFifo.sv
src/openCLFullPipeline.sv
testbench/tbOpenCLFullPipeline.sv
